// File: ifu.f
verilog/ifu_pkg.sv
verilog/ifu_pc_select.sv
verilog/ifu_prefetch_buffer.sv
verilog/ifu_id_stage_reg.sv
verilog/ifu_pc_check.sv
verilog/ifu_top.sv
testbench/ifu_properties.sv
testbench/ifu_tb.sv

// File: Makefile
# Verilator build and run for the instruction fetch unit

VERILATOR ?= verilator
TOP       ?= ifu_tb
FILELIST  ?= ifu.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

PASS_TEXT := All checks passed

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) && echo "simulation passed" || \
	  (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: testbench/ifu_tb.sv
`timescale 1ns/100ps

module ifu_tb;

  import ifu_pkg::*;

  localparam addr_t DmHalt     = 32'h0000_A800;
  localparam addr_t DmExc      = 32'h0000_A808;
  localparam addr_t ErrLo      = 32'h0000_3010;
  localparam addr_t ErrHi      = 32'h0000_3018;
  localparam instr_t WordMix   = 32'h5A3C_96E1;
  // limit allows 20 cycles per word for the 100 words of all tests, plus reset
  localparam int TotalWords    = 100;
  localparam int CycleLimit    = 300 + TotalWords * 20;

  typedef struct packed {
    instr_t word;
    logic   err;
  } mem_resp_t;

  logic clk_i;
  logic rst_ni;
  logic instr_req_o;
  addr_t instr_addr_o;
  logic instr_gnt_i;
  logic instr_rvalid_i;
  instr_t instr_rdata_i;
  logic instr_err_i;
  logic req_i;
  logic pc_set_i;
  pc_sel_e pc_mux_i;
  exc_pc_sel_e exc_pc_mux_i;
  logic instr_valid_clear_i;
  logic id_in_ready_i;
  addr_t boot_addr_i;
  addr_t branch_target_ex_i;
  addr_t csr_mtvec_i;
  addr_t csr_mepc_i;
  addr_t csr_depc_i;
  logic csr_mtvec_init_o;
  logic instr_valid_id_o;
  logic instr_new_id_o;
  id_instr_t id_instr_o;
  addr_t pc_if_o;
  logic if_busy_o;
  logic pc_mismatch_alert_o;

  integer seed = 32'h8594_7bd7;
  int cycles = 0;
  int mem_cycle = 0;
  int last_due = 0;
  int errors = 0;
  int words_seen = 0;
  int err_words = 0;
  int test_words;
  int test_errors;
  logic bp_mode = 1'b0;
  logic valid_exp = 1'b0;
  addr_t exp_pc = '0;
  addr_t pend_addr[$];
  int pend_due[$];

  ifu_top #(
    .DmHaltAddr      (DmHalt),
    .DmExceptionAddr (DmExc),
    .FifoDepth       (3)
  ) ifu_top_i (.*);

  initial clk_i = 1'b0;
  always #2 clk_i = ~clk_i;

  // expected memory word is the address mixed with a constant
  function automatic mem_resp_t ref_resp(addr_t addr);
    mem_resp_t r;
    r.word = {addr[15:0], addr[31:16]} ^ WordMix;
    r.err  = (addr >= ErrLo) && (addr < ErrHi);
    return r;
  endfunction

  task automatic report_error(string msg);
    $display("FAILED at %0t: %s", $time, msg);
    errors++;
  endtask

  // bus memory model that also drives random ID stalls in back-pressure mode
  always begin
    mem_resp_t r;
    int due;
    @(negedge clk_i);
    mem_cycle++;
    if (pend_addr.size() > 0 && pend_due[0] <= mem_cycle) begin
      r = ref_resp(pend_addr[0]);
      instr_rvalid_i = 1'b1;
      instr_rdata_i  = r.word;
      instr_err_i    = r.err;
      void'(pend_addr.pop_front());
      void'(pend_due.pop_front());
    end else begin
      instr_rvalid_i = 1'b0;
      instr_rdata_i  = '0;
      instr_err_i    = 1'b0;
    end
    instr_gnt_i = ($random(seed) & 3) != 0;
    if (bp_mode) begin
      id_in_ready_i = ($random(seed) & 1) != 0;
    end
    // sample the request just before the rising edge
    #1;
    if (instr_req_o && instr_gnt_i) begin
      due = mem_cycle + 1 + int'($unsigned($random(seed)) % 32'd3);
      if (due <= last_due) begin
        due = last_due + 1;
      end
      last_due = due;
      pend_addr.push_back(instr_addr_o);
      pend_due.push_back(due);
    end
  end

  // compare process runs one ns after each rising edge
  always begin
    mem_resp_t r;
    @(posedge clk_i);
    #1;
    if (rst_ni) begin
      if (pc_mismatch_alert_o) begin
        report_error("pc_mismatch_alert_o high");
      end
      if (instr_new_id_o) begin
        r = ref_resp(exp_pc);
        if (id_instr_o.pc != exp_pc) begin
          report_error($sformatf("pc %h, expected %h", id_instr_o.pc, exp_pc));
        end
        if (id_instr_o.instr != r.word) begin
          report_error($sformatf("instr %h at %h, expected %h",
                                 id_instr_o.instr, exp_pc, r.word));
        end
        if (id_instr_o.fetch_err != r.err) begin
          report_error($sformatf("fetch_err %b at %h", id_instr_o.fetch_err, exp_pc));
        end
        if (id_instr_o.fetch_err) begin
          err_words++;
        end
        exp_pc = exp_pc + 32'd4;
        words_seen++;
        valid_exp = 1'b1;
      end
      if (instr_valid_id_o != valid_exp) begin
        report_error($sformatf("instr_valid_id_o %b, expected %b",
                               instr_valid_id_o, valid_exp));
      end
      // the head of the buffer always holds the next PC in sequence
      if (pc_if_o != exp_pc) begin
        report_error($sformatf("pc_if_o %h, expected %h", pc_if_o, exp_pc));
      end
      if (if_busy_o != (pend_addr.size() != 0)) begin
        report_error($sformatf("if_busy_o %b with %0d requests outstanding",
                               if_busy_o, pend_addr.size()));
      end
    end
  end

  always @(posedge clk_i) begin
    cycles++;
    if (cycles >= CycleLimit) begin
      $display("timeout: run stopped after %0d cycles, only %0d words arrived",
               cycles, words_seen);
      $display("Checks failed");
      $finish;
    end
  end

  task automatic start_test();
    test_words  = words_seen;
    test_errors = errors;
  endtask

  task automatic end_test(string name);
    $display("test %s done: %0d words, %0d errors", name,
             words_seen - test_words, errors - test_errors);
  endtask

  // set the PC and wait for n words of the new stream
  task automatic redirect(pc_sel_e sel, exc_pc_sel_e esel, addr_t target, int n);
    int goal;
    @(negedge clk_i);
    pc_mux_i     = sel;
    exc_pc_mux_i = esel;
    pc_set_i     = 1'b1;
    exp_pc       = target;
    goal         = words_seen + n;
    #1;
    if (csr_mtvec_init_o != (sel == PC_BOOT)) begin
      report_error($sformatf("csr_mtvec_init_o %b with pc_mux %0d", csr_mtvec_init_o, sel));
    end
    @(negedge clk_i);
    pc_set_i = 1'b0;
    while (words_seen < goal) begin
      @(negedge clk_i);
    end
  endtask

  initial begin
    rst_ni = 1'b0;
    instr_gnt_i = 1'b0;
    instr_rvalid_i = 1'b0;
    instr_rdata_i = '0;
    instr_err_i = 1'b0;
    req_i = 1'b0;
    pc_set_i = 1'b0;
    pc_mux_i = PC_BOOT;
    exc_pc_mux_i = EXC_PC_EXC;
    instr_valid_clear_i = 1'b0;
    id_in_ready_i = 1'b1;
    boot_addr_i = 32'h0000_1003;
    branch_target_ex_i = 32'h0000_4000;
    csr_mtvec_i = 32'h0000_8007;
    csr_mepc_i = 32'h0000_6100;
    csr_depc_i = 32'h0000_7200;
    repeat (10) @(negedge clk_i);
    rst_ni = 1'b1;
    req_i  = 1'b1;

    start_test();
    redirect(PC_BOOT, EXC_PC_EXC, 32'h0000_1000, 12);
    end_test("boot");

    start_test();
    redirect(PC_JUMP, EXC_PC_EXC, 32'h0000_4000, 8);
    redirect(PC_ERET, EXC_PC_EXC, 32'h0000_6100, 8);
    redirect(PC_DRET, EXC_PC_EXC, 32'h0000_7200, 8);
    end_test("redirect");

    start_test();
    redirect(PC_EXC, EXC_PC_EXC, 32'h0000_8004, 6);
    redirect(PC_EXC, EXC_PC_DBD, DmHalt, 6);
    redirect(PC_EXC, EXC_PC_DBG_EXC, DmExc, 6);
    end_test("exc_vector");

    start_test();
    branch_target_ex_i = 32'h0000_2000;
    bp_mode = 1'b1;
    redirect(PC_JUMP, EXC_PC_EXC, 32'h0000_2000, 40);
    bp_mode = 1'b0;
    @(negedge clk_i);
    // stall ID and clear the valid flag
    id_in_ready_i = 1'b0;
    instr_valid_clear_i = 1'b1;
    valid_exp = 1'b0;
    @(negedge clk_i);
    instr_valid_clear_i = 1'b0;
    if (instr_valid_id_o) begin
      report_error("instr_valid_id_o still high after instr_valid_clear_i");
    end
    id_in_ready_i = 1'b1;
    end_test("backpress");

    start_test();
    err_words = 0;
    branch_target_ex_i = 32'h0000_3008;
    redirect(PC_JUMP, EXC_PC_EXC, 32'h0000_3008, 6);
    if (err_words != 2) begin
      report_error($sformatf("%0d words with fetch_err, expected 2", err_words));
    end
    end_test("bus_error");

    repeat (5) @(negedge clk_i);
    $display("summary: %0d words checked, %0d errors, %0d cycles", words_seen, errors, cycles);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

// File: testbench/ifu_properties.sv
`timescale 1ns/100ps

module ifu_properties (
  input logic           clk_i,
  input logic           rst_ni,
  input logic           instr_req_o,
  input logic           instr_gnt_i,
  input ifu_pkg::addr_t instr_addr_o,
  input logic           instr_valid_id_o,
  input logic           instr_new_id_o,
  input logic           id_in_ready_i
);

  // a waiting request keeps its address
  addr_stable_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    instr_req_o && !instr_gnt_i |=> $stable(instr_addr_o))
    else $error("instr_addr_o changed while a request was waiting for grant");

  // nothing valid in ID right after reset
  valid_after_reset_a : assert property (@(posedge clk_i)
    $rose(rst_ni) |-> !instr_valid_id_o)
    else $error("instr_valid_id_o high out of reset");

  // a stalled ID stage takes nothing
  no_new_when_stalled_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    !id_in_ready_i |=> !instr_new_id_o)
    else $error("instr_new_id_o rose while id_in_ready_i was low");

endmodule

bind ifu_top ifu_properties props_i (
  .clk_i            (clk_i),
  .rst_ni           (rst_ni),
  .instr_req_o      (instr_req_o),
  .instr_gnt_i      (instr_gnt_i),
  .instr_addr_o     (instr_addr_o),
  .instr_valid_id_o (instr_valid_id_o),
  .instr_new_id_o   (instr_new_id_o),
  .id_in_ready_i    (id_in_ready_i)
);

// File: verilog/ifu_top.sv
`timescale 1ns/100ps

module ifu_top #(
  parameter ifu_pkg::addr_t DmHaltAddr      = 32'h1A11_0800,
  parameter ifu_pkg::addr_t DmExceptionAddr = 32'h1A11_0808,
  parameter int unsigned    FifoDepth       = 3
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  // instruction bus
  output logic                 instr_req_o,
  output ifu_pkg::addr_t       instr_addr_o,
  input  logic                 instr_gnt_i,
  input  logic                 instr_rvalid_i,
  input  ifu_pkg::instr_t      instr_rdata_i,
  input  logic                 instr_err_i,
  // control from the core
  input  logic                 req_i,
  input  logic                 pc_set_i,
  input  ifu_pkg::pc_sel_e     pc_mux_i,
  input  ifu_pkg::exc_pc_sel_e exc_pc_mux_i,
  input  logic                 instr_valid_clear_i,
  input  logic                 id_in_ready_i,
  // address sources
  input  ifu_pkg::addr_t       boot_addr_i,
  input  ifu_pkg::addr_t       branch_target_ex_i,
  input  ifu_pkg::addr_t       csr_mtvec_i,
  input  ifu_pkg::addr_t       csr_mepc_i,
  input  ifu_pkg::addr_t       csr_depc_i,
  // outputs
  output logic                 csr_mtvec_init_o,
  output logic                 instr_valid_id_o,
  output logic                 instr_new_id_o,
  output ifu_pkg::id_instr_t   id_instr_o,
  output ifu_pkg::addr_t       pc_if_o,
  output logic                 if_busy_o,
  output logic                 pc_mismatch_alert_o
);

  import ifu_pkg::*;

  addr_t       fetch_target;
  logic        fetch_valid;
  logic        fetch_ready;
  fetch_word_t fetch_word;
  logic        if_id_we;

  ifu_pc_select #(
    .DmHaltAddr      (DmHaltAddr),
    .DmExceptionAddr (DmExceptionAddr)
  ) pc_select_i (
    .pc_set_i           (pc_set_i),
    .pc_mux_i           (pc_mux_i),
    .exc_pc_mux_i       (exc_pc_mux_i),
    .boot_addr_i        (boot_addr_i),
    .branch_target_ex_i (branch_target_ex_i),
    .csr_mtvec_i        (csr_mtvec_i),
    .csr_mepc_i         (csr_mepc_i),
    .csr_depc_i         (csr_depc_i),
    .fetch_target_o     (fetch_target),
    .csr_mtvec_init_o   (csr_mtvec_init_o)
  );

  // pc_set_i doubles as the branch strobe of the buffer
  ifu_prefetch_buffer #(
    .FifoDepth (FifoDepth)
  ) prefetch_buffer_i (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .req_i          (req_i),
    .branch_i       (pc_set_i),
    .branch_addr_i  (fetch_target),
    .ready_i        (fetch_ready),
    .valid_o        (fetch_valid),
    .word_o         (fetch_word),
    .instr_req_o    (instr_req_o),
    .instr_addr_o   (instr_addr_o),
    .instr_gnt_i    (instr_gnt_i),
    .instr_rvalid_i (instr_rvalid_i),
    .instr_rdata_i  (instr_rdata_i),
    .instr_err_i    (instr_err_i),
    .busy_o         (if_busy_o)
  );

  ifu_id_stage_reg id_stage_reg_i (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .fetch_valid_i       (fetch_valid),
    .fetch_word_i        (fetch_word),
    .id_in_ready_i       (id_in_ready_i),
    .pc_set_i            (pc_set_i),
    .instr_valid_clear_i (instr_valid_clear_i),
    .fetch_ready_o       (fetch_ready),
    .if_id_we_o          (if_id_we),
    .instr_valid_id_o    (instr_valid_id_o),
    .instr_new_id_o      (instr_new_id_o),
    .id_instr_o          (id_instr_o)
  );

  ifu_pc_check pc_check_i (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .if_id_we_i          (if_id_we),
    .branch_i            (pc_set_i),
    .fetch_valid_i       (fetch_valid),
    .pc_if_i             (pc_if_o),
    .pc_id_i             (id_instr_o.pc),
    .pc_mismatch_alert_o (pc_mismatch_alert_o)
  );

  // PC of the word at the head of the buffer
  assign pc_if_o = fetch_word.addr;

endmodule

// File: verilog/ifu_pc_check.sv
`timescale 1ns/100ps

module ifu_pc_check (
  input  logic           clk_i,
  input  logic           rst_ni,
  input  logic           if_id_we_i,
  input  logic           branch_i,
  input  logic           fetch_valid_i,
  input  ifu_pkg::addr_t pc_if_i,
  input  ifu_pkg::addr_t pc_id_i,
  output logic           pc_mismatch_alert_o
);

  import ifu_pkg::*;

  logic  seq_d;
  logic  seq_q;
  addr_t pc_expected;

  // any redirect restarts the check, the next take re-arms it
  assign seq_d = (seq_q | if_id_we_i) & ~branch_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      seq_q <= 1'b0;
    end else begin
      seq_q <= seq_d;
    end
  end

  assign pc_expected = pc_id_i + addr_t'(INSTR_BYTES);

  // head of the buffer must follow the word now in ID
  assign pc_mismatch_alert_o = seq_q & fetch_valid_i & (pc_if_i != pc_expected);

endmodule

// File: verilog/ifu_id_stage_reg.sv
`timescale 1ns/100ps

module ifu_id_stage_reg (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 fetch_valid_i,
  input  ifu_pkg::fetch_word_t fetch_word_i,
  input  logic                 id_in_ready_i,
  input  logic                 pc_set_i,
  input  logic                 instr_valid_clear_i,
  output logic                 fetch_ready_o,
  output logic                 if_id_we_o,
  output logic                 instr_valid_id_o,
  output logic                 instr_new_id_o,
  output ifu_pkg::id_instr_t   id_instr_o
);

  logic valid_d;
  logic valid_q;
  logic new_q;

  // ID accepts whenever it is ready
  assign fetch_ready_o = id_in_ready_i;
  assign if_id_we_o    = fetch_valid_i & id_in_ready_i;

  // a take in a pc_set cycle is squashed
  // valid then holds until the core clears it
  assign valid_d = (if_id_we_o & ~pc_set_i) | (valid_q & ~instr_valid_clear_i);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
      new_q   <= 1'b0;
    end else begin
      valid_q <= valid_d;
      new_q   <= if_id_we_o;
    end
  end

  assign instr_valid_id_o = valid_q;
  assign instr_new_id_o   = new_q;

  // register frozen while ID is stalled
  always_ff @(posedge clk_i) begin
    if (if_id_we_o) begin
      id_instr_o <= '{
        instr:     fetch_word_i.instr,
        pc:        fetch_word_i.addr,
        fetch_err: fetch_word_i.err
      };
    end
  end

endmodule

// File: verilog/ifu_prefetch_buffer.sv
`timescale 1ns/100ps

module ifu_prefetch_buffer #(
  parameter int unsigned FifoDepth = 3
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 req_i,
  input  logic                 branch_i,
  input  ifu_pkg::addr_t       branch_addr_i,
  input  logic                 ready_i,
  output logic                 valid_o,
  output ifu_pkg::fetch_word_t word_o,
  output logic                 instr_req_o,
  output ifu_pkg::addr_t       instr_addr_o,
  input  logic                 instr_gnt_i,
  input  logic                 instr_rvalid_i,
  input  ifu_pkg::instr_t      instr_rdata_i,
  input  logic                 instr_err_i,
  output logic                 busy_o
);

  import ifu_pkg::*;

  localparam int unsigned CntW = $clog2(FifoDepth + 1);
  localparam int unsigned PtrW = $clog2(FifoDepth);
  localparam logic [CntW:0] CreditMax = (CntW + 1)'(FifoDepth);

  typedef logic [CntW-1:0] cnt_t;
  typedef logic [PtrW-1:0] ptr_t;

  logic          fetch_en_q;
  addr_t         fetch_addr_q;
  addr_t         resp_addr_q;
  cnt_t          out_cnt_q;
  cnt_t          out_cnt_d;
  cnt_t          discard_q;
  cnt_t          discard_d;
  cnt_t          fifo_cnt_q;
  cnt_t          fifo_cnt_d;
  ptr_t          rd_ptr_q;
  ptr_t          wr_ptr_q;
  fetch_word_t   fifo_mem [FifoDepth];
  logic [CntW:0] credit_used;
  logic          granted;
  logic          in_valid;
  fetch_word_t   in_word;
  logic          fifo_empty;
  logic          push;
  logic          pop;

  function automatic ptr_t ptr_next(ptr_t ptr);
    if (ptr == ptr_t'(FifoDepth - 1)) begin
      return '0;
    end
    return ptr + ptr_t'(1);
  endfunction

  // words held plus words still on the bus must fit in the FIFO
  assign credit_used = {1'b0, fifo_cnt_q} + {1'b0, out_cnt_q};

  // the branch cycle itself issues nothing, the new stream starts one cycle later
  assign instr_req_o  = req_i & fetch_en_q & ~branch_i & (credit_used < CreditMax);
  assign instr_addr_o = fetch_addr_q;
  assign granted      = instr_req_o & instr_gnt_i;
  assign busy_o       = (out_cnt_q != '0);

  always_comb begin
    out_cnt_d = out_cnt_q;
    if (granted && !instr_rvalid_i) begin
      out_cnt_d = out_cnt_q + cnt_t'(1);
    end else if (!granted && instr_rvalid_i) begin
      out_cnt_d = out_cnt_q - cnt_t'(1);
    end
  end

  // on a redirect everything still in flight belongs to the old stream
  always_comb begin
    discard_d = discard_q;
    if (branch_i) begin
      discard_d = out_cnt_d;
    end else if (instr_rvalid_i && (discard_q != '0)) begin
      discard_d = discard_q - cnt_t'(1);
    end
  end

  assign in_valid = instr_rvalid_i & (discard_q == '0) & ~branch_i;
  assign in_word  = '{instr: instr_rdata_i, addr: resp_addr_q, err: instr_err_i};

  // an empty FIFO passes the response straight through
  assign fifo_empty = (fifo_cnt_q == '0);
  assign valid_o    = ~branch_i & (~fifo_empty | in_valid);
  assign word_o     = fifo_empty ? in_word : fifo_mem[rd_ptr_q];
  assign pop        = ~fifo_empty & ready_i & ~branch_i;
  assign push       = in_valid & ~(fifo_empty & ready_i);

  always_comb begin
    fifo_cnt_d = fifo_cnt_q;
    if (branch_i) begin
      fifo_cnt_d = '0;
    end else if (push && !pop) begin
      fifo_cnt_d = fifo_cnt_q + cnt_t'(1);
    end else if (!push && pop) begin
      fifo_cnt_d = fifo_cnt_q - cnt_t'(1);
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      fetch_en_q   <= 1'b0;
      fetch_addr_q <= '0;
      resp_addr_q  <= '0;
      out_cnt_q    <= '0;
      discard_q    <= '0;
      fifo_cnt_q   <= '0;
      rd_ptr_q     <= '0;
      wr_ptr_q     <= '0;
    end else begin
      out_cnt_q  <= out_cnt_d;
      discard_q  <= discard_d;
      fifo_cnt_q <= fifo_cnt_d;
      if (branch_i) begin
        // no fetching until the core has set a PC
        fetch_en_q   <= 1'b1;
        fetch_addr_q <= branch_addr_i;
        resp_addr_q  <= branch_addr_i;
        rd_ptr_q     <= '0;
        wr_ptr_q     <= '0;
      end else begin
        if (granted) begin
          fetch_addr_q <= fetch_addr_q + addr_t'(INSTR_BYTES);
        end
        // responses return in order, so the tag just counts up
        if (in_valid) begin
          resp_addr_q <= resp_addr_q + addr_t'(INSTR_BYTES);
        end
        if (pop) begin
          rd_ptr_q <= ptr_next(rd_ptr_q);
        end
        if (push) begin
          wr_ptr_q <= ptr_next(wr_ptr_q);
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      fifo_mem[wr_ptr_q] <= in_word;
    end
  end

endmodule

// File: verilog/ifu_pc_select.sv
`timescale 1ns/100ps

module ifu_pc_select #(
  parameter ifu_pkg::addr_t DmHaltAddr      = 32'h1A11_0800,
  parameter ifu_pkg::addr_t DmExceptionAddr = 32'h1A11_0808
) (
  input  logic                 pc_set_i,
  input  ifu_pkg::pc_sel_e     pc_mux_i,
  input  ifu_pkg::exc_pc_sel_e exc_pc_mux_i,
  input  ifu_pkg::addr_t       boot_addr_i,
  input  ifu_pkg::addr_t       branch_target_ex_i,
  input  ifu_pkg::addr_t       csr_mtvec_i,
  input  ifu_pkg::addr_t       csr_mepc_i,
  input  ifu_pkg::addr_t       csr_depc_i,
  output ifu_pkg::addr_t       fetch_target_o,
  output logic                 csr_mtvec_init_o
);

  import ifu_pkg::*;

  addr_t exc_pc;

  // force an address onto a word boundary
  function automatic addr_t align_word(addr_t addr);
    return {addr[$bits(addr_t)-1:ALIGN_BITS], {ALIGN_BITS{1'b0}}};
  endfunction

  // exception vector
  always_comb begin
    unique case (exc_pc_mux_i)
      EXC_PC_EXC:     exc_pc = align_word(csr_mtvec_i);
      EXC_PC_DBD:     exc_pc = DmHaltAddr;
      EXC_PC_DBG_EXC: exc_pc = DmExceptionAddr;
      default:        exc_pc = align_word(csr_mtvec_i);
    endcase
  end

  // fetch target
  always_comb begin
    unique case (pc_mux_i)
      PC_BOOT: fetch_target_o = align_word(boot_addr_i);
      PC_JUMP: fetch_target_o = branch_target_ex_i;
      PC_EXC:  fetch_target_o = exc_pc;
      PC_ERET: fetch_target_o = csr_mepc_i;
      PC_DRET: fetch_target_o = csr_depc_i;
      default: fetch_target_o = align_word(boot_addr_i);
    endcase
  end

  // mtvec gets its initial value when the core boots
  assign csr_mtvec_init_o = pc_set_i & (pc_mux_i == PC_BOOT);

endmodule

// File: verilog/ifu_pkg.sv
package ifu_pkg;

  // byte address and raw instruction word
  typedef logic [31:0] addr_t;
  typedef logic [31:0] instr_t;

  // every fetch is one aligned 32-bit word
  localparam int unsigned INSTR_BYTES = 4;
  localparam int unsigned ALIGN_BITS  = 2;

  // fetch target select, driven by the core on pc_set
  typedef enum logic [2:0] {
    PC_BOOT = 3'd0,
    PC_JUMP = 3'd1,
    PC_EXC  = 3'd2,
    PC_ERET = 3'd3,
    PC_DRET = 3'd4
  } pc_sel_e;

  // exception vector select
  typedef enum logic [1:0] {
    // trap handler base from mtvec
    EXC_PC_EXC     = 2'd0,
    // debug module halt entry
    EXC_PC_DBD     = 2'd1,
    // debug module exception entry
    EXC_PC_DBG_EXC = 2'd2
  } exc_pc_sel_e;

  // one word as delivered by the prefetch buffer
  typedef struct packed {
    instr_t instr;
    addr_t  addr;
    logic   err;
  } fetch_word_t;

  // instruction held in the IF-ID register
  typedef struct packed {
    instr_t instr;
    addr_t  pc;
    logic   fetch_err;
  } id_instr_t;

endpackage
